//--- all.f
design/sys_pkg.sv
design/clock_enables.sv
design/sync_ram.sv
design/bus_noise.sv
design/main_bus_arbiter.sv
design/zbus_arbiter.sv
design/md_bus_top.sv
tests/tb_md_bus.sv

//--- design/bus_noise.sv
`timescale 1ns/10ps

module bus_noise import sys_pkg::*; (
	input  logic  MCLK,
	input  logic  step,
	output word_t noise_data
);

	// 17-bit LFSR and the open-bus shift register
	logic [16:0] lfsr = '0;
	word_t       noise_q = '0;

	always_ff @(posedge MCLK) begin
		if (step) begin
			// All-zero term kicks the register out of the lockup state
			lfsr    <= {lfsr[0] ^ lfsr[2] ^ ~|lfsr, lfsr[16:1]};
			noise_q <= {noise_q[14:0], lfsr[0]};
		end
	end

	assign noise_data = noise_q;

endmodule

//--- design/clock_enables.sv
`timescale 1ns/10ps

module clock_enables import sys_pkg::*; (
	input  logic   MCLK,
	input  logic   reset,
	input  turbo_t turbo,
	input  logic   z80_hold,
	output logic   cpu_ce_p,
	output logic   cpu_ce_n,
	output logic   z80_ce
);

	// 68000 phase counter with period end and mid point
	logic [3:0] vcnt;
	logic [3:0] vmax;
	logic [3:0] vmid;

	// Z80 divider, fixed 15 cycles
	logic [3:0] zcnt;
	logic       z80_tick;

	always_ff @(posedge MCLK) begin
		if (reset) begin
			vcnt     <= 4'd0;
			vmax     <= 4'd6;
			vmid     <= 4'd3;
			zcnt     <= 4'd0;
			cpu_ce_p <= 1'b1;
			cpu_ce_n <= 1'b0;
			z80_tick <= 1'b1;
		end else begin
			cpu_ce_p <= 1'b0;
			vcnt     <= vcnt + 4'd1;
			if (vcnt == vmax) begin
				vcnt     <= 4'd0;
				cpu_ce_p <= 1'b1;
				// New period length only takes effect at a period boundary
				case (turbo)
					2'd1: begin
						vmax <= 4'd3;
						vmid <= 4'd1;
					end
					2'd2, 2'd3: begin
						vmax <= 4'd1;
						vmid <= 4'd0;
					end
					default: begin
						vmax <= 4'd6;
						vmid <= 4'd3;
					end
				endcase
			end

			cpu_ce_n <= (vcnt == vmid);

			z80_tick <= 1'b0;
			zcnt     <= zcnt + 4'd1;
			if (zcnt == 4'd14) begin
				zcnt     <= 4'd0;
				z80_tick <= 1'b1;
			end
		end
	end

	// Z80 stalls while the 68000 holds its bus
	assign z80_ce = z80_tick & ~z80_hold;

	a_phase_exclusive: assert property (@(posedge MCLK) disable iff (reset)
		!(cpu_ce_p && cpu_ce_n))
		else $error("cpu_ce_p and cpu_ce_n high together");

endmodule

//--- design/main_bus_arbiter.sv
`timescale 1ns/10ps

module main_bus_arbiter import sys_pkg::*; #(
	parameter int WRAM_AW = sys_pkg::WRAM_AW
) (
	input  logic       MCLK,
	input  logic       reset,
	input  logic       cpu_ce_n,
	input  logic       m68k_as_n,
	input  logic       m68k_uds_n,
	input  logic       m68k_lds_n,
	input  logic       m68k_rnw,
	input  mbus_addr_t m68k_addr,
	input  word_t      m68k_dout,
	output word_t      m68k_din,
	output logic       m68k_dtack_n,
	input  logic       z80_mbus_req,
	input  logic [15:0] z80_addr,
	input  logic       z80_wr_n,
	input  byte_t      z80_dout,
	output byte_t      z80_mbus_data,
	output logic       z80_mbus_dtack_n,
	output logic       zbus_sel,
	output mbus_addr_t mbus_addr,
	output word_t      mbus_dout,
	output logic       mbus_rnw,
	output logic       mbus_uds_n,
	input  byte_t      mbus_zbus_data,
	input  logic       mbus_zbus_dtack_n,
	input  bank_t      bank,
	output logic       z80_busreq,
	output logic       z80_reset_n,
	input  word_t      noise_data
);

	mstate_t mstate;
	msrc_t   msrc;
	word_t   data;
	logic    mbus_lds_n;
	logic    ram_sel;
	word_t   ram_q;
	logic    ctrl_hit;
	logic    ctrl_bit;

	// A11100 bus request, A11200 Z80 reset
	assign ctrl_hit = (mbus_addr[23:12] == 12'hA11) && (mbus_addr[7:1] == 7'd0);
	assign ctrl_bit = (mbus_addr[11:8] == 4'h1) ? z80_busreq :
	                  (mbus_addr[11:8] == 4'h2) ? z80_reset_n : noise_data[8];

	// --------------------
	// Work RAM
	// --------------------

	sync_ram #(.ADDR_W(WRAM_AW)) u_wram_hi (
		.MCLK  (MCLK),
		.addr  (mbus_addr[WRAM_AW:1]),
		.wdata (mbus_dout[15:8]),
		.we    (ram_sel & ~mbus_rnw & ~mbus_uds_n),
		.rdata (ram_q[15:8])
	);

	sync_ram #(.ADDR_W(WRAM_AW)) u_wram_lo (
		.MCLK  (MCLK),
		.addr  (mbus_addr[WRAM_AW:1]),
		.wdata (mbus_dout[7:0]),
		.we    (ram_sel & ~mbus_rnw & ~mbus_lds_n),
		.rdata (ram_q[7:0])
	);

	// --------------------
	// Bus state machine
	// --------------------

	always_ff @(posedge MCLK) begin
		if (reset) begin
			mstate           <= MS_IDLE;
			msrc             <= SRC_NONE;
			m68k_dtack_n     <= 1'b1;
			z80_mbus_dtack_n <= 1'b1;
			zbus_sel         <= 1'b0;
			ram_sel          <= 1'b0;
			mbus_rnw         <= 1'b1;
			mbus_uds_n       <= 1'b1;
			mbus_lds_n       <= 1'b1;
			z80_busreq       <= 1'b0;
			z80_reset_n      <= 1'b0;
		end else begin
			// Acknowledge is held until the master lets go
			if (m68k_as_n) m68k_dtack_n <= 1'b1;
			if (!z80_mbus_req) z80_mbus_dtack_n <= 1'b1;

			case (mstate)
				MS_IDLE: begin
					if (!m68k_as_n && m68k_dtack_n && cpu_ce_n) begin
						msrc       <= SRC_M68K;
						mbus_addr  <= m68k_addr;
						mbus_dout  <= m68k_dout;
						mbus_rnw   <= m68k_rnw;
						mbus_uds_n <= m68k_uds_n;
						mbus_lds_n <= m68k_lds_n;
						data       <= noise_data;
						mstate     <= MS_SELECT;
					end else if (z80_mbus_req && z80_mbus_dtack_n) begin
						msrc       <= SRC_Z80;
						// Bank window above 8000, 7Fxx lands on the unmapped C000xx
						mbus_addr  <= z80_addr[15] ? {bank, z80_addr[14:1]} :
						                             {16'hC000, z80_addr[7:1]};
						mbus_dout  <= {z80_dout, z80_dout};
						mbus_rnw   <= z80_wr_n;
						mbus_uds_n <= z80_addr[0];
						mbus_lds_n <= ~z80_addr[0];
						data       <= noise_data;
						mstate     <= MS_SELECT;
					end
				end

				MS_SELECT: begin
					mstate <= MS_FINISH;
					if (mbus_addr[23:20] < 4'hA) begin
						// No cartridge
						data <= '0;
					end else if (mbus_addr[23:16] == 8'hA0) begin
						mstate <= MS_ZBUS_PRE;
					end else if (ctrl_hit) begin
						data <= {noise_data[15:9], ctrl_bit, noise_data[7:0]};
						if (!mbus_rnw && !mbus_uds_n) begin
							if (mbus_addr[11:8] == 4'h1) z80_busreq <= mbus_dout[8];
							if (mbus_addr[11:8] == 4'h2) z80_reset_n <= mbus_dout[8];
						end
					end else if (&mbus_addr[23:21]) begin
						// E00000-FFFFFF, 64 KB mirrored
						ram_sel <= 1'b1;
						mstate  <= MS_RAM_READ;
					end
				end

				MS_RAM_READ: begin
					ram_sel <= 1'b0;
					data    <= ram_q;
					mstate  <= MS_FINISH;
				end

				MS_ZBUS_PRE: begin
					if (msrc == SRC_M68K) begin
						// Wait for the data strobes before picking a lane
						if (m68k_as_n || !m68k_uds_n || !m68k_lds_n) begin
							mbus_uds_n <= m68k_uds_n;
							mbus_lds_n <= m68k_lds_n;
							zbus_sel   <= 1'b1;
							mstate     <= MS_ZBUS_READ;
						end
					end else begin
						zbus_sel <= 1'b1;
						mstate   <= MS_ZBUS_READ;
					end
				end

				MS_ZBUS_READ: begin
					if (!mbus_zbus_dtack_n) begin
						zbus_sel <= 1'b0;
						data     <= {mbus_zbus_data, mbus_zbus_data};
						mstate   <= MS_FINISH;
					end
				end

				MS_FINISH: begin
					case (msrc)
						SRC_M68K: begin
							if (m68k_as_n) begin
								mstate <= MS_IDLE;
							end else begin
								m68k_din     <= data;
								m68k_dtack_n <= 1'b0;
							end
						end
						SRC_Z80: begin
							if (!z80_mbus_req) begin
								mstate <= MS_IDLE;
							end else begin
								z80_mbus_data    <= z80_addr[0] ? data[7:0] : data[15:8];
								z80_mbus_dtack_n <= 1'b0;
							end
						end
						default: mstate <= MS_IDLE;
					endcase
				end

				default: mstate <= MS_IDLE;
			endcase
		end
	end

	a_dtack_needs_as: assert property (@(posedge MCLK) disable iff (reset)
		$fell(m68k_dtack_n) |-> !$past(m68k_as_n))
		else $error("m68k_dtack_n fell without an address strobe");

	a_zbus_from_decode: assert property (@(posedge MCLK) disable iff (reset)
		$rose(zbus_sel) |-> (mbus_addr[23:16] == 8'hA0) && (msrc != SRC_NONE))
		else $error("Z80-bus select outside the A0xxxx decode");

endmodule

//--- design/md_bus_top.sv
`timescale 1ns/10ps

module md_bus_top import sys_pkg::*; #(
	parameter int WRAM_AW = sys_pkg::WRAM_AW,
	parameter int ZRAM_AW = sys_pkg::ZRAM_AW
) (
	input  logic        MCLK,
	input  logic        reset,
	input  turbo_t      turbo,
	input  logic        m68k_as_n,
	input  logic        m68k_uds_n,
	input  logic        m68k_lds_n,
	input  logic        m68k_rnw,
	input  mbus_addr_t  m68k_addr,
	input  word_t       m68k_dout,
	output word_t       m68k_din,
	output logic        m68k_dtack_n,
	input  logic        z80_mreq_n,
	input  logic        z80_rd_n,
	input  logic        z80_wr_n,
	input  logic [15:0] z80_addr,
	input  byte_t       z80_dout,
	output byte_t       z80_din,
	output logic        z80_dtack_n,
	output logic        z80_ce,
	output logic        z80_reset_n,
	output logic        cpu_ce_p,
	output logic        cpu_ce_n
);

	logic       z80_io;
	logic       z80_zbus_hit;
	logic       z80_zbus_req;
	logic       z80_mbus_req;
	byte_t      z80_mbus_data;
	logic       z80_mbus_dtack_n;
	byte_t      z80_zbus_data;
	logic       z80_zbus_dtack_n;
	logic       zbus_sel;
	mbus_addr_t mbus_addr;
	word_t      mbus_dout;
	logic       mbus_rnw;
	logic       mbus_uds_n;
	byte_t      mbus_zbus_data;
	logic       mbus_zbus_dtack_n;
	bank_t      bank;
	logic       z80_busreq;
	word_t      noise_data;

	// Z80 0000-7EFF stays local, the rest goes out to the main bus
	assign z80_io       = ~z80_mreq_n & (~z80_rd_n | ~z80_wr_n);
	assign z80_zbus_hit = ~z80_addr[15] & ~&z80_addr[14:8];
	assign z80_zbus_req = z80_io & z80_zbus_hit;
	assign z80_mbus_req = z80_io & ~z80_zbus_hit;

	assign z80_din     = !z80_zbus_dtack_n ? z80_zbus_data : z80_mbus_data;
	assign z80_dtack_n = z80_zbus_dtack_n & z80_mbus_dtack_n;

	clock_enables u_clk (
		.MCLK     (MCLK),
		.reset    (reset),
		.turbo    (turbo),
		.z80_hold (z80_busreq),
		.cpu_ce_p (cpu_ce_p),
		.cpu_ce_n (cpu_ce_n),
		.z80_ce   (z80_ce)
	);

	bus_noise u_noise (
		.MCLK       (MCLK),
		.step       (cpu_ce_p),
		.noise_data (noise_data)
	);

	main_bus_arbiter #(.WRAM_AW(WRAM_AW)) u_mbus (
		.MCLK              (MCLK),
		.reset             (reset),
		.cpu_ce_n          (cpu_ce_n),
		.m68k_as_n         (m68k_as_n),
		.m68k_uds_n        (m68k_uds_n),
		.m68k_lds_n        (m68k_lds_n),
		.m68k_rnw          (m68k_rnw),
		.m68k_addr         (m68k_addr),
		.m68k_dout         (m68k_dout),
		.m68k_din          (m68k_din),
		.m68k_dtack_n      (m68k_dtack_n),
		.z80_mbus_req      (z80_mbus_req),
		.z80_addr          (z80_addr),
		.z80_wr_n          (z80_wr_n),
		.z80_dout          (z80_dout),
		.z80_mbus_data     (z80_mbus_data),
		.z80_mbus_dtack_n  (z80_mbus_dtack_n),
		.zbus_sel          (zbus_sel),
		.mbus_addr         (mbus_addr),
		.mbus_dout         (mbus_dout),
		.mbus_rnw          (mbus_rnw),
		.mbus_uds_n        (mbus_uds_n),
		.mbus_zbus_data    (mbus_zbus_data),
		.mbus_zbus_dtack_n (mbus_zbus_dtack_n),
		.bank              (bank),
		.z80_busreq        (z80_busreq),
		.z80_reset_n       (z80_reset_n),
		.noise_data        (noise_data)
	);

	zbus_arbiter #(.ZRAM_AW(ZRAM_AW)) u_zbus (
		.MCLK              (MCLK),
		.reset             (reset),
		.zbus_sel          (zbus_sel),
		.mbus_addr         (mbus_addr),
		.mbus_dout         (mbus_dout),
		.mbus_rnw          (mbus_rnw),
		.mbus_uds_n        (mbus_uds_n),
		.mbus_zbus_data    (mbus_zbus_data),
		.mbus_zbus_dtack_n (mbus_zbus_dtack_n),
		.z80_zbus_req      (z80_zbus_req),
		.z80_addr          (z80_addr),
		.z80_wr_n          (z80_wr_n),
		.z80_dout          (z80_dout),
		.z80_zbus_data     (z80_zbus_data),
		.z80_zbus_dtack_n  (z80_zbus_dtack_n),
		.z80_busreq        (z80_busreq),
		.z80_reset_n       (z80_reset_n),
		.bank              (bank)
	);

endmodule

//--- design/sync_ram.sv
`timescale 1ns/10ps

module sync_ram import sys_pkg::*; #(
	parameter int ADDR_W = 13
) (
	input  logic              MCLK,
	input  logic [ADDR_W-1:0] addr,
	input  byte_t             wdata,
	input  logic              we,
	output byte_t             rdata
);

	byte_t mem [2**ADDR_W];

	// Read-before-write, data one cycle after the address
	always_ff @(posedge MCLK) begin
		if (we) begin
			mem[addr] <= wdata;
		end
		rdata <= mem[addr];
	end

endmodule

//--- design/sys_pkg.sv
package sys_pkg;

	// --------------------
	// Memory sizes
	// --------------------

	// Work RAM, 32K words per lane pair
	localparam int WRAM_AW = 15;
	// Z80 RAM, 8 KB
	localparam int ZRAM_AW = 13;

	// --------------------
	// Bus words
	// --------------------

	typedef logic [15:0] word_t;
	typedef logic [7:0]  byte_t;

	// 68000 word address, byte address bits 23..1
	typedef logic [23:1] mbus_addr_t;
	typedef logic [14:0] zbus_addr_t;

	// Z80 bank window, main-bus address bits 23..15
	typedef logic [8:0]  bank_t;

	// 0 normal, 1 double, 2 quadruple
	typedef logic [1:0]  turbo_t;

	// --------------------
	// Main-bus arbiter
	// --------------------

	typedef enum logic [1:0] {
		SRC_NONE,
		SRC_M68K,
		SRC_Z80
	} msrc_t;

	typedef enum logic [2:0] {
		MS_IDLE,
		MS_SELECT,
		MS_RAM_READ,
		MS_ZBUS_PRE,
		MS_ZBUS_READ,
		MS_FINISH
	} mstate_t;

endpackage

//--- design/zbus_arbiter.sv
`timescale 1ns/10ps

module zbus_arbiter import sys_pkg::*; #(
	parameter int ZRAM_AW = sys_pkg::ZRAM_AW
) (
	input  logic        MCLK,
	input  logic        reset,
	input  logic        zbus_sel,
	input  mbus_addr_t  mbus_addr,
	input  word_t       mbus_dout,
	input  logic        mbus_rnw,
	input  logic        mbus_uds_n,
	output byte_t       mbus_zbus_data,
	output logic        mbus_zbus_dtack_n,
	input  logic        z80_zbus_req,
	input  logic [15:0] z80_addr,
	input  logic        z80_wr_n,
	input  byte_t       z80_dout,
	output byte_t       z80_zbus_data,
	output logic        z80_zbus_dtack_n,
	input  logic        z80_busreq,
	input  logic        z80_reset_n,
	output bank_t       bank
);

	typedef enum logic [1:0] {
		ZS_IDLE,
		ZS_READ,
		ZS_FINISH
	} zstate_t;

	zstate_t    zstate;
	logic       zsrc_z80;
	zbus_addr_t zbus_a;
	byte_t      zbus_do;
	logic       zbus_we;
	byte_t      zram_q;
	byte_t      zbus_di;
	logic       zbus_free;
	logic       zram_sel;
	logic       bank_sel;

	// 68000 side only gets through with the bus granted and the Z80 running
	assign zbus_free = z80_busreq & z80_reset_n;

	// 0000-3FFF RAM, 6000-60FF bank latch
	assign zram_sel = ~zbus_a[14];
	assign bank_sel = (zbus_a[14:8] == 7'h60);

	// FM space and everything else float high
	assign zbus_di = zram_sel ? zram_q : 8'hFF;

	sync_ram #(.ADDR_W(ZRAM_AW)) u_zram (
		.MCLK  (MCLK),
		.addr  (zbus_a[ZRAM_AW-1:0]),
		.wdata (zbus_do),
		.we    (zbus_we & zram_sel),
		.rdata (zram_q)
	);

	always_ff @(posedge MCLK) begin
		if (reset) begin
			zstate            <= ZS_IDLE;
			zsrc_z80          <= 1'b0;
			zbus_we           <= 1'b0;
			mbus_zbus_dtack_n <= 1'b1;
			z80_zbus_dtack_n  <= 1'b1;
		end else begin
			zbus_we <= 1'b0;
			if (!zbus_sel) mbus_zbus_dtack_n <= 1'b1;
			if (!z80_zbus_req) z80_zbus_dtack_n <= 1'b1;

			case (zstate)
				ZS_IDLE: begin
					// Nothing new until both previous acknowledges are gone
					if (mbus_zbus_dtack_n && z80_zbus_dtack_n) begin
						if (zbus_sel) begin
							zbus_a   <= {mbus_addr[14:1], mbus_uds_n};
							zbus_do  <= !mbus_uds_n ? mbus_dout[15:8] : mbus_dout[7:0];
							zbus_we  <= ~mbus_rnw & zbus_free;
							zsrc_z80 <= 1'b0;
							zstate   <= ZS_READ;
						end else if (z80_zbus_req) begin
							zbus_a   <= z80_addr[14:0];
							zbus_do  <= z80_dout;
							zbus_we  <= ~z80_wr_n;
							zsrc_z80 <= 1'b1;
							zstate   <= ZS_READ;
						end
					end
				end

				ZS_READ: zstate <= ZS_FINISH;

				ZS_FINISH: begin
					if (zsrc_z80) begin
						z80_zbus_data    <= zbus_di;
						z80_zbus_dtack_n <= 1'b0;
					end else begin
						mbus_zbus_data    <= zbus_free ? zbus_di : 8'hFF;
						mbus_zbus_dtack_n <= 1'b0;
					end
					zstate <= ZS_IDLE;
				end

				default: zstate <= ZS_IDLE;
			endcase
		end
	end

	// --------------------
	// Bank register
	// --------------------

	// Nine serial writes of bit 0, first one ends up in bit 15 of the address
	always_ff @(posedge MCLK) begin
		if (reset) begin
			bank <= '0;
		end else if (bank_sel && zbus_we) begin
			bank <= {zbus_do[0], bank[8:1]};
		end
	end

	a_one_owner: assert property (@(posedge MCLK) disable iff (reset)
		mbus_zbus_dtack_n || z80_zbus_dtack_n)
		else $error("Z80 bus acknowledged to both sides at once");

endmodule

//--- tests/tb_md_bus.sv
`timescale 1ns/10ps

module tb_md_bus import sys_pkg::*; ();

	localparam int TIMEOUT = 200;

	logic        MCLK;
	logic        reset;
	turbo_t      turbo;
	logic        m68k_as_n;
	logic        m68k_uds_n;
	logic        m68k_lds_n;
	logic        m68k_rnw;
	mbus_addr_t  m68k_addr;
	word_t       m68k_dout;
	word_t       m68k_din;
	logic        m68k_dtack_n;
	logic        z80_mreq_n;
	logic        z80_rd_n;
	logic        z80_wr_n;
	logic [15:0] z80_addr;
	byte_t       z80_dout;
	byte_t       z80_din;
	logic        z80_dtack_n;
	logic        z80_ce;
	logic        z80_reset_n;
	logic        cpu_ce_p;
	logic        cpu_ce_n;

	int mismatch_count;
	int other_count;

	// One bus access, byte address and expected read data
	typedef struct packed {
		logic        z80;
		logic        rnw;
		logic [23:0] addr;
		logic [15:0] wdata;
		logic        uds_n;
		logic        lds_n;
		logic [15:0] exp_data;
		logic [15:0] mask;
	} step_t;

	step_t steps[$];
	string notes[$];

	// Expected work RAM contents, indexed by byte address bits 15..1
	word_t wram_model [0:32767];

	md_bus_top #(.WRAM_AW(WRAM_AW), .ZRAM_AW(ZRAM_AW)) UUT (.*);

	always #10 MCLK = ~MCLK;

	// --------------------
	// Run control
	// --------------------

	task automatic finish_run();
		$display("Errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
		if (mismatch_count == 0 && other_count == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	endtask

	task automatic give_up(input string what);
		other_count++;
		$display("Timed out at %0t waiting for %s", $time, what);
		finish_run();
	endtask

	task automatic check_value(input string note, input word_t got, input word_t exp,
	                           input word_t mask);
		assert ((got & mask) == (exp & mask)) else begin
			mismatch_count++;
			$display("Mismatch at %0t: %s got %h expected %h mask %h",
			         $time, note, got, exp, mask);
		end
	endtask

	// --------------------
	// Handshakes
	// --------------------

	task automatic wait_dtack(input bit z80_side, input logic level, input string what);
		int n;
		n = 0;
		while ((z80_side ? z80_dtack_n : m68k_dtack_n) !== level && n < TIMEOUT) begin
			@(negedge MCLK);
			n++;
		end
		if ((z80_side ? z80_dtack_n : m68k_dtack_n) !== level) begin
			give_up(what);
		end
	endtask

	task automatic m68k_access(input step_t s, output word_t rdata);
		@(negedge MCLK);
		m68k_addr  = s.addr[23:1];
		m68k_dout  = s.wdata;
		m68k_rnw   = s.rnw;
		m68k_uds_n = s.uds_n;
		m68k_lds_n = s.lds_n;
		m68k_as_n  = 1'b0;
		wait_dtack(1'b0, 1'b0, "m68k_dtack_n to fall");
		rdata      = m68k_din;
		m68k_as_n  = 1'b1;
		m68k_uds_n = 1'b1;
		m68k_lds_n = 1'b1;
		m68k_rnw   = 1'b1;
		wait_dtack(1'b0, 1'b1, "m68k_dtack_n to rise");
	endtask

	task automatic z80_access(input step_t s, output word_t rdata);
		@(negedge MCLK);
		z80_addr   = s.addr[15:0];
		z80_dout   = s.wdata[7:0];
		z80_mreq_n = 1'b0;
		if (s.rnw) begin
			z80_rd_n = 1'b0;
		end else begin
			z80_wr_n = 1'b0;
		end
		wait_dtack(1'b1, 1'b0, "z80_dtack_n to fall");
		rdata      = {8'h00, z80_din};
		z80_mreq_n = 1'b1;
		z80_rd_n   = 1'b1;
		z80_wr_n   = 1'b1;
		wait_dtack(1'b1, 1'b1, "z80_dtack_n to rise");
	endtask

	// --------------------
	// Stimulus table
	// --------------------

	task automatic add_step(input bit z80, input bit rnw, input logic [23:0] addr,
	                        input word_t wdata, input bit uds_n, input bit lds_n,
	                        input word_t exp, input word_t mask, input string note);
		steps.push_back({z80, rnw, addr, wdata, uds_n, lds_n, exp, mask});
		notes.push_back(note);
	endtask

	task automatic wram_write(input logic [23:0] addr, input word_t data,
	                          input bit uds_n, input bit lds_n);
		if (!uds_n) wram_model[addr[15:1]][15:8] = data[15:8];
		if (!lds_n) wram_model[addr[15:1]][7:0] = data[7:0];
		add_step(0, 0, addr, data, uds_n, lds_n, 16'h0000, 16'h0000,
		         $sformatf("work RAM write %h", addr));
	endtask

	task automatic wram_read(input logic [23:0] addr);
		add_step(0, 1, addr, 16'h0000, 0, 0, wram_model[addr[15:1]], 16'hFFFF,
		         $sformatf("work RAM read %h", addr));
	endtask

	// Bank fixed at 1FF, so Z80 8000-FFFF is FF8000-FFFFFF
	task automatic bank_read(input logic [15:0] zaddr);
		logic [23:0] a;
		byte_t       b;
		a = {9'h1FF, zaddr[14:0]};
		b = a[0] ? wram_model[a[15:1]][7:0] : wram_model[a[15:1]][15:8];
		add_step(1, 1, {8'h00, zaddr}, 16'h0000, 1, 1, {8'h00, b}, 16'h00FF,
		         $sformatf("Z80 bank read %h", zaddr));
	endtask

	task automatic bank_write(input logic [15:0] zaddr, input byte_t b);
		logic [23:0] a;
		a = {9'h1FF, zaddr[14:0]};
		if (a[0]) begin
			wram_model[a[15:1]][7:0] = b;
		end else begin
			wram_model[a[15:1]][15:8] = b;
		end
		add_step(1, 0, {8'h00, zaddr}, {8'h00, b}, 1, 1, 16'h0000, 16'h0000,
		         $sformatf("Z80 bank write %h", zaddr));
	endtask

	task automatic run_table();
		word_t got;
		foreach (steps[i]) begin
			if (steps[i].z80) begin
				z80_access(steps[i], got);
			end else begin
				m68k_access(steps[i], got);
			end
			check_value(notes[i], got, steps[i].exp_data, steps[i].mask);
		end
		steps.delete();
		notes.delete();
	endtask

	// --------------------
	// Clock enables
	// --------------------

	task automatic wait_cpu_ce(input int count);
		int n;
		int seen;
		n    = 0;
		seen = 0;
		while (seen < count && n < TIMEOUT) begin
			@(negedge MCLK);
			n++;
			if (cpu_ce_p) seen++;
		end
		if (seen < count) begin
			give_up("cpu_ce_p after a turbo change");
		end
	endtask

	task automatic check_period(input bit z80_side, input int period, input string what);
		int  since;
		int  pulses;
		int  mid_at;
		int  mids;
		bit  seen;
		since  = 0;
		pulses = 0;
		mid_at = -1;
		mids   = 0;
		seen   = 1'b0;
		repeat (200) begin
			@(negedge MCLK);
			since++;
			if (!z80_side && cpu_ce_n) begin
				mid_at = since;
				mids++;
			end
			if (z80_side ? z80_ce : cpu_ce_p) begin
				if (seen) begin
					pulses++;
					check_value($sformatf("%s period", what), since, period, 16'hFFFF);
					if (!z80_side) begin
						// One cpu_ce_n pulse, half a period after cpu_ce_p
						check_value($sformatf("%s cpu_ce_n pulses", what), mids, 1,
						            16'hFFFF);
						assert (mid_at >= period / 2 && mid_at <= (period + 1) / 2)
						else begin
							mismatch_count++;
							$display("Mismatch at %0t: %s cpu_ce_n at cycle %0d of the period",
							         $time, what, mid_at);
						end
					end
				end
				seen   = 1'b1;
				since  = 0;
				mid_at = -1;
				mids   = 0;
			end
		end
		assert (pulses > 0) else begin
			other_count++;
			$display("No full %s period seen within 200 cycles", what);
		end
	endtask

	// --------------------
	// Main sequence
	// --------------------

	initial begin
		word_t       w;
		byte_t       b;
		byte_t       zbytes [4];
		logic [15:0] zoffs [4];
		logic [15:0] off;
		logic [4:0]  mir;
		int          periods [3];

		MCLK       = 1'b0;
		reset      = 1'b1;
		turbo      = 2'd0;
		m68k_as_n  = 1'b1;
		m68k_uds_n = 1'b1;
		m68k_lds_n = 1'b1;
		m68k_rnw   = 1'b1;
		m68k_addr  = '0;
		m68k_dout  = '0;
		z80_mreq_n = 1'b1;
		z80_rd_n   = 1'b1;
		z80_wr_n   = 1'b1;
		z80_addr   = '0;
		z80_dout   = '0;
		mismatch_count = 0;
		other_count    = 0;
		void'($urandom(32'hf06c));
		zoffs   = '{16'h0000, 16'h0001, 16'h0123, 16'h1FFF};
		periods = '{7, 4, 2};

		repeat (8) @(posedge MCLK);
		@(negedge MCLK);
		reset = 1'b0;
		check_value("m68k_dtack_n after reset", {15'd0, m68k_dtack_n}, 16'h0001, 16'h0001);
		check_value("z80_dtack_n after reset", {15'd0, z80_dtack_n}, 16'h0001, 16'h0001);
		check_value("z80_reset_n after reset", {15'd0, z80_reset_n}, 16'h0000, 16'h0001);
		check_value("cpu_ce_p after reset", {15'd0, cpu_ce_p}, 16'h0001, 16'h0001);
		check_value("z80_ce after reset", {15'd0, z80_ce}, 16'h0001, 16'h0001);

		// Work RAM with byte lanes and 64 KB mirrors
		w = $urandom;
		wram_write(24'hE01234, w, 0, 0);
		b = $urandom;
		wram_write(24'hE01235, {8'h00, b}, 1, 0);
		wram_read(24'hF31234);
		w = $urandom;
		wram_write(24'hFFFE00, w, 0, 0);
		b = $urandom;
		wram_write(24'hEAFE00, {b, 8'h00}, 0, 1);
		wram_read(24'hE0FE00);
		for (int k = 0; k < 6; k++) begin
			off = $urandom & 16'hFFFE;
			w   = $urandom;
			mir = k * 7 + 3;
			wram_write({8'hE0, off}, w, 0, 0);
			wram_read({3'b111, mir, off});
		end
		run_table();

		// Z80 control registers, Z80 bus closed to the 68000
		add_step(0, 1, 24'hA11100, 0, 0, 0, 16'h0000, 16'h0100, "busreq after reset");
		add_step(0, 1, 24'hA11200, 0, 0, 0, 16'h0000, 16'h0100, "Z80 reset after reset");
		add_step(1, 0, 24'h000010, 16'h0011, 1, 1, 0, 0, "Z80 write 0010");
		add_step(0, 0, 24'hA00010, 16'h5A5A, 0, 0, 0, 0, "closed write A00010");
		add_step(0, 1, 24'hA00000, 0, 0, 0, 16'hFFFF, 16'hFFFF, "closed read A00000");
		add_step(0, 0, 24'hA11100, 16'h0100, 0, 0, 0, 0, "set busreq");
		add_step(0, 0, 24'hA11200, 16'h0100, 0, 0, 0, 0, "release Z80 reset");
		add_step(0, 1, 24'hA11100, 0, 0, 0, 16'h0100, 16'h0100, "busreq readback");
		add_step(0, 1, 24'hA11200, 0, 0, 0, 16'h0100, 16'h0100, "Z80 reset readback");
		run_table();
		check_value("z80_reset_n after release", {15'd0, z80_reset_n}, 16'h0001, 16'h0001);

		// Z80 RAM shared by both masters
		add_step(0, 1, 24'hA00010, 0, 0, 0, 16'h1111, 16'hFFFF, "lost write A00010");
		for (int k = 0; k < 4; k++) begin
			zbytes[k] = $urandom;
			add_step(0, 0, {8'hA0, zoffs[k]},
			         zoffs[k][0] ? {8'h00, zbytes[k]} : {zbytes[k], 8'h00},
			         zoffs[k][0], ~zoffs[k][0], 0, 0, "68000 Z80 RAM write");
		end
		for (int k = 0; k < 4; k++) begin
			add_step(1, 1, {8'h00, zoffs[k]}, 0, 1, 1, {8'h00, zbytes[k]}, 16'h00FF,
			         $sformatf("Z80 RAM read %h", zoffs[k]));
			add_step(1, 1, {8'h00, zoffs[k] | 16'h2000}, 0, 1, 1, {8'h00, zbytes[k]},
			         16'h00FF, $sformatf("Z80 RAM mirror read %h", zoffs[k]));
			add_step(0, 1, {8'hA0, zoffs[k]}, 0, zoffs[k][0], ~zoffs[k][0],
			         {zbytes[k], zbytes[k]}, 16'hFFFF, "68000 Z80 RAM read");
		end
		add_step(1, 1, 24'h004000, 0, 1, 1, 16'h00FF, 16'h00FF, "FM space 4000");
		add_step(1, 1, 24'h005FFF, 0, 1, 1, 16'h00FF, 16'h00FF, "FM space 5FFF");
		run_table();

		// Bank window onto FF8000
		add_step(0, 0, 24'hA11100, 16'h0000, 0, 0, 0, 0, "release busreq");
		wram_write(24'hFF8000, $urandom, 0, 0);
		wram_write(24'hFF8002, $urandom, 0, 0);
		wram_write(24'hFF8100, $urandom, 0, 0);
		wram_write(24'hFFFFFE, $urandom, 0, 0);
		repeat (9) begin
			add_step(1, 0, 24'h006000, 16'h0001, 1, 1, 0, 0, "bank shift");
		end
		bank_read(16'h8000);
		bank_read(16'h8001);
		bank_read(16'h8002);
		bank_read(16'h8003);
		bank_read(16'hFFFE);
		bank_read(16'hFFFF);
		bank_write(16'h8101, $urandom);
		wram_read(24'hFF8100);
		bank_write(16'h8100, $urandom);
		wram_read(24'hFF8100);
		add_step(1, 1, 24'h007F11, 0, 1, 1, 0, 0, "Z80 7Fxx page");
		run_table();

		// Unmapped cartridge space and open bus
		add_step(0, 1, 24'h000000, 0, 0, 0, 16'h0000, 16'hFFFF, "no ROM 000000");
		add_step(0, 1, 24'h123456, 0, 0, 0, 16'h0000, 16'hFFFF, "no ROM 123456");
		add_step(0, 1, 24'h9FFFFE, 0, 0, 0, 16'h0000, 16'hFFFF, "no ROM 9FFFFE");
		add_step(0, 1, 24'hC00000, 0, 0, 0, 16'h0000, 16'h0000, "open bus C00000");
		run_table();

		for (int t = 0; t < 3; t++) begin
			@(negedge MCLK);
			turbo = t;
			wait_cpu_ce(2);
			check_period(1'b0, periods[t], $sformatf("cpu_ce_p turbo %0d", t));
		end
		@(negedge MCLK);
		turbo = 2'd0;
		check_period(1'b1, 15, "z80_ce");

		// Z80 stalls while the bus is requested
		add_step(0, 0, 24'hA11100, 16'h0100, 0, 0, 0, 0, "set busreq again");
		run_table();
		repeat (200) begin
			@(negedge MCLK);
			check_value("z80_ce under busreq", {15'd0, z80_ce}, 16'h0000, 16'h0001);
		end

		finish_run();
	end

endmodule
